/* cacheGeomPkg.sv */
// cache geometry constants and width types, imported by every flush block that handles addresses or data
`default_nettype none

package cacheGeomPkg;

  //////////////////////////////
  // fixed geometry
  //////////////////////////////

  // one data word on the shadow write port
  localparam int WordBits = 32;
  // words held by one cache line
  localparam int WordsPerLine = 4;
  // byte address width seen by the cache
  localparam int AdrBits = 16;
  // upper bound on the way count, sets the way number width
  localparam int MaxWays = 4;

  //////////////////////////////
  // width types
  //////////////////////////////

  // a single data word
  typedef logic [WordBits-1:0] cacheWord_t;
  // a byte address
  typedef logic [AdrBits-1:0] physAdr_t;
  // a way number, wide enough for MaxWays
  typedef logic [$clog2(MaxWays)-1:0] wayIdx_t;
  // a full line, word 0 in the low bits
  typedef logic [WordsPerLine-1:0][WordBits-1:0] cacheLine_t;

endpackage

`default_nettype wire

/* flushPkg.sv */
// flush engine record types and drain states, shared by the cache array, snapshots and drain
`default_nettype none

package flushPkg;

  //////////////////////////////
  // fill port
  //////////////////////////////

  // one line loaded into the cache per accepted fill
  typedef struct packed {
    // line base byte address, offset bits ignored
    cacheGeomPkg::physAdr_t   adr;
    cacheGeomPkg::wayIdx_t    way;
    logic                     dirty;
    logic                     valid;
    cacheGeomPkg::cacheLine_t data;
  } fillReq_t;

  //////////////////////////////
  // line state and shadow writes
  //////////////////////////////

  // what the array presents for one way and index, and what a snapshot holds
  typedef struct packed {
    logic                     valid;
    logic                     dirty;
    // base address rebuilt from tag and index
    cacheGeomPkg::physAdr_t   adr;
    cacheGeomPkg::cacheLine_t data;
  } lineState_t;

  // one word written to the shadow memory
  typedef struct packed {
    cacheGeomPkg::physAdr_t   adr;
    cacheGeomPkg::cacheWord_t data;
  } shadowWrite_t;

  // drain FSM
  typedef enum logic [1:0] {
    idle,
    scan,
    emit,
    finish
  } drainState_t;

endpackage

`default_nettype wire

/* cacheArray.sv */
// tag, valid, dirty and data storage for all ways and indexes, loaded by fills and read by snapshots
`timescale 1ns/1ps
`default_nettype none

module cacheArray #(
  parameter int NumWays  = 2,
  parameter int NumLines = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 fillValid,
  input  flushPkg::fillReq_t   fill,
  input  logic                 busy,
  output logic                 fillReady,
  output flushPkg::lineState_t lines [NumWays][NumLines]
);
  import cacheGeomPkg::*;
  import flushPkg::*;

  // byte offset inside a line, then index, then tag
  localparam int OffBits = $clog2(WordsPerLine * WordBits / 8);
  // NumLines is a power of two, at least 2
  localparam int IdxBits = $clog2(NumLines);
  localparam int TagBits = AdrBits - OffBits - IdxBits;

  logic [TagBits-1:0] tagMem   [NumWays][NumLines];
  logic               validMem [NumWays][NumLines];
  logic               dirtyMem [NumWays][NumLines];
  cacheLine_t         dataMem  [NumWays][NumLines];

  logic               fillTake;
  logic [IdxBits-1:0] fillIdx;
  logic [TagBits-1:0] fillTag;
  logic               wrEn     [NumWays][NumLines];

  // fills are held off for the whole flush
  assign fillReady = ~busy;
  assign fillTake  = fillValid & fillReady;

  // split the fill address
  assign fillIdx = fill.adr[OffBits +: IdxBits];
  assign fillTag = fill.adr[OffBits + IdxBits +: TagBits];

  //////////////////////////////
  // fill decode
  //////////////////////////////

  // one-hot line select, ways beyond NumWays never match
  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      for (int i = 0; i < NumLines; i++) begin
        wrEn[w][i] = fillTake && (fill.way == wayIdx_t'(w)) && (fillIdx == IdxBits'(i));
      end
    end
  end

  //////////////////////////////
  // storage
  //////////////////////////////

  // valid bits, the only state cleared by reset
  always_ff @(posedge clk) begin
    for (int w = 0; w < NumWays; w++) begin
      for (int i = 0; i < NumLines; i++) begin
        if (rst) begin
          validMem[w][i] <= 1'b0;
        end else if (wrEn[w][i]) begin
          validMem[w][i] <= fill.valid;
        end
      end
    end
  end

  // tag, dirty and data, only meaningful behind a valid bit
  always_ff @(posedge clk) begin
    for (int w = 0; w < NumWays; w++) begin
      for (int i = 0; i < NumLines; i++) begin
        if (wrEn[w][i]) begin
          tagMem[w][i]   <= fillTag;
          dirtyMem[w][i] <= fill.dirty;
          dataMem[w][i]  <= fill.data;
        end
      end
    end
  end

  // present every line in parallel, base address = tag, index, zero offset
  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      for (int i = 0; i < NumLines; i++) begin
        lines[w][i].valid = validMem[w][i];
        lines[w][i].dirty = dirtyMem[w][i];
        lines[w][i].adr   = {tagMem[w][i], IdxBits'(i), OffBits'(0)};
        lines[w][i].data  = dataMem[w][i];
      end
    end
  end

endmodule

`default_nettype wire

/* lineSnapshot.sv */
// capture register for one cache line, frozen on flush start and read by the drain
`timescale 1ns/1ps
`default_nettype none

module lineSnapshot (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  flushPkg::lineState_t line,
  output flushPkg::lineState_t snap
);

  logic                                   validQ;
  logic                                   dirtyQ;
  logic [$bits(line.adr)-1:0]             adrQ;
  logic [$bits(line.data)-1:0]            dataQ;

  // control bits, cleared to an invalid line
  always_ff @(posedge clk) begin
    if (rst) begin
      validQ <= 1'b0;
      dirtyQ <= 1'b0;
    end else if (start) begin
      validQ <= line.valid;
      // dirty only counts behind a valid line
      dirtyQ <= line.valid & line.dirty;
    end
  end

  // address and data, loaded on the same edge
  always_ff @(posedge clk) begin
    if (start) begin
      adrQ  <= line.adr;
      dataQ <= line.data;
    end
  end

  assign snap = {validQ, dirtyQ, adrQ, dataQ};

endmodule

`default_nettype wire

/* shadowDrain.sv */
// drain FSM that walks the snapshots and writes every dirty line out word by word
`timescale 1ns/1ps
`default_nettype none

module shadowDrain #(
  parameter int NumWays  = 2,
  parameter int NumLines = 8
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  flushPkg::lineState_t   snaps [NumWays][NumLines],
  input  logic                   shadowReady,
  output logic                   shadowValid,
  output flushPkg::shadowWrite_t shadowWr,
  output logic                   busy,
  output logic                   done
);
  import cacheGeomPkg::*;
  import flushPkg::*;

  // counter widths, at least one bit each
  localparam int IdxBits   = (NumLines > 1) ? $clog2(NumLines) : 1;
  localparam int WayBits   = (NumWays > 1) ? $clog2(NumWays) : 1;
  localparam int WordCntBits = $clog2(WordsPerLine);
  localparam int WordBytes = WordBits / 8;

  drainState_t            state;
  logic [IdxBits-1:0]     idxCnt;
  logic [WayBits-1:0]     wayCnt;
  logic [WordCntBits-1:0] wordCnt;
  logic [WordCntBits-1:0] nextWord;
  logic [IdxBits-1:0]     stepIdx;
  logic [WayBits-1:0]     stepWay;
  lineState_t             cur;
  logic                   hasDirty;
  logic                   lastWay;
  logic                   lastLine;
  logic                   lastWord;
  logic                   accept;

  //////////////////////////////
  // scan position
  //////////////////////////////

  // line under the scan pointer
  assign cur      = snaps[wayCnt][idxCnt];
  assign hasDirty = cur.valid & cur.dirty;

  assign lastWay  = (wayCnt == WayBits'(NumWays - 1));
  assign lastLine = lastWay && (idxCnt == IdxBits'(NumLines - 1));
  assign lastWord = (wordCnt == WordCntBits'(WordsPerLine - 1));
  assign nextWord = wordCnt + 1'b1;
  assign accept   = shadowValid & shadowReady;

  // way is the inner loop, index the outer one
  always_comb begin
    if (lastWay) begin
      stepWay = '0;
      stepIdx = idxCnt + 1'b1;
    end else begin
      stepWay = wayCnt + 1'b1;
      stepIdx = idxCnt;
    end
  end

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= idle;
      idxCnt      <= '0;
      wayCnt      <= '0;
      wordCnt     <= '0;
      shadowValid <= 1'b0;
    end else begin
      case (state)
        // finish also takes a start, busy is already low there
        idle, finish: begin
          if (start) begin
            state  <= scan;
            idxCnt <= '0;
            wayCnt <= '0;
          end else begin
            state <= idle;
          end
        end
        // one cycle per line, a dirty line raises valid on the next cycle
        scan: begin
          if (hasDirty) begin
            state       <= emit;
            wordCnt     <= '0;
            shadowValid <= 1'b1;
          end else if (lastLine) begin
            state <= finish;
          end else begin
            idxCnt <= stepIdx;
            wayCnt <= stepWay;
          end
        end
        // hold the write until it is taken
        emit: begin
          if (accept) begin
            if (!lastWord) begin
              wordCnt <= nextWord;
            end else begin
              shadowValid <= 1'b0;
              if (lastLine) begin
                state <= finish;
              end else begin
                state  <= scan;
                idxCnt <= stepIdx;
                wayCnt <= stepWay;
              end
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // write payload, changes only on entry to emit or after an accepted word
  always_ff @(posedge clk) begin
    if (state == scan && hasDirty) begin
      shadowWr.adr  <= cur.adr;
      shadowWr.data <= cur.data[0];
    end else if (state == emit && accept && !lastWord) begin
      shadowWr.adr  <= cur.adr + (physAdr_t'(nextWord) * physAdr_t'(WordBytes));
      shadowWr.data <= cur.data[nextWord];
    end
  end

  // busy drops in the done cycle
  assign busy = (state == scan) || (state == emit);
  assign done = (state == finish);

endmodule

`default_nettype wire

/* cacheShadowTop.sv */
// flush engine top level: cache array, one snapshot per line and the shadow drain
`timescale 1ns/1ps
`default_nettype none

module cacheShadowTop #(
  parameter int NumWays  = 2,
  parameter int NumLines = 8
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fillValid,
  input  flushPkg::fillReq_t     fill,
  output logic                   fillReady,
  input  logic                   start,
  output logic                   shadowValid,
  output flushPkg::shadowWrite_t shadowWr,
  input  logic                   shadowReady,
  output logic                   done
);
  import flushPkg::*;

  logic       busy;
  lineState_t lines [NumWays][NumLines];
  lineState_t snaps [NumWays][NumLines];

  //////////////////////////////
  // cache storage
  //////////////////////////////

  cacheArray #(
    .NumWays  (NumWays),
    .NumLines (NumLines)
  ) array (
    .clk       (clk),
    .rst       (rst),
    .fillValid (fillValid),
    .fill      (fill),
    .busy      (busy),
    .fillReady (fillReady),
    .lines     (lines)
  );

  //////////////////////////////
  // snapshots
  //////////////////////////////

  // whole cache frozen in one edge, a start during a flush leaves it alone
  for (genvar w = 0; w < NumWays; w++) begin : gWay
    for (genvar i = 0; i < NumLines; i++) begin : gLine
      lineSnapshot snapReg (
        .clk   (clk),
        .rst   (rst),
        .start (start & ~busy),
        .line  (lines[w][i]),
        .snap  (snaps[w][i])
      );
    end
  end

  // drain
  shadowDrain #(
    .NumWays  (NumWays),
    .NumLines (NumLines)
  ) drain (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .snaps       (snaps),
    .shadowReady (shadowReady),
    .shadowValid (shadowValid),
    .shadowWr    (shadowWr),
    .busy        (busy),
    .done        (done)
  );

endmodule

`default_nettype wire

/* cacheShadow_sva.sv */
// port-level protocol checks for the flush engine, bound into the top level by the testbench
`timescale 1ns/1ps
`default_nettype none

module cacheShadow_sva (
  input logic                   clk,
  input logic                   rst,
  input logic                   fillReady,
  input logic                   start,
  input logic                   shadowValid,
  input flushPkg::shadowWrite_t shadowWr,
  input logic                   shadowReady,
  input logic                   done
);

  // failures seen so far, read by the testbench at the end
  int failCount = 0;

  //////////////////////////////
  // shadow write handshake
  //////////////////////////////

  // a stalled write keeps valid and payload
  holdWrite: assert property (@(posedge clk) disable iff (rst)
    (shadowValid && !shadowReady) |=> (shadowValid && $stable(shadowWr)))
    else begin
      failCount++;
      $error("shadow write dropped or changed while stalled");
    end

  // no write offered outside a flush
  quietIdle: assert property (@(posedge clk) disable iff (rst)
    fillReady |-> !shadowValid)
    else begin
      failCount++;
      $error("shadow write offered while the drain is idle");
    end

  //////////////////////////////
  // flush framing
  //////////////////////////////

  // fills blocked from the cycle after start up to done
  blockFills: assert property (@(posedge clk) disable iff (rst)
    (start && fillReady) |=> (!fillReady until done))
    else begin
      failCount++;
      $error("fill port opened during a flush");
    end

  // done closes the flush, never with a pending write
  doneAlone: assert property (@(posedge clk) disable iff (rst)
    !(done && shadowValid))
    else begin
      failCount++;
      $error("done raised while a shadow write is pending");
    end

  // done is a single-cycle pulse
  donePulse: assert property (@(posedge clk) disable iff (rst)
    done |=> !done)
    else begin
      failCount++;
      $error("done held for more than one cycle");
    end

endmodule

`default_nettype wire

/* tb_cacheShadow.sv */
// testbench for the flush engine: fills the cache, runs flushes and scores the shadow writes
`timescale 1ns/1ps
`default_nettype none

module tb_cacheShadow;
  import cacheGeomPkg::*;
  import flushPkg::*;

  //////////////////////////////
  // run constants
  //////////////////////////////

  localparam int Seed = 35197;
  localparam int ClkPeriod = 4;
  localparam int NumWays = 2;
  localparam int NumLines = 8;
  localparam int LineBytes = 16;
  localparam int WordBytes = 4;
  // percent of cycles with shadowReady low
  localparam int BackPressurePct = 30;
  localparam int NumFlushes = 5;
  localparam int NumFills = 64;
  // worst flush allows 20 stall cycles per word
  localparam int FlushCycles = NumWays * NumLines * (2 + WordsPerLine * 20) + 8;
  localparam int TimeoutCycles = NumFlushes * FlushCycles + NumFills * 3 + 200;

  logic         clk = 1'b0;
  logic         rst;
  logic         fillValid;
  fillReq_t     fill;
  logic         fillReady;
  logic         start;
  logic         shadowValid;
  shadowWrite_t shadowWr;
  logic         shadowReady;
  logic         done;

  // reference copy of the cache contents
  logic         refValid [NumWays][NumLines];
  logic         refDirty [NumWays][NumLines];
  physAdr_t     refAdr   [NumWays][NumLines];
  cacheLine_t   refData  [NumWays][NumLines];
  shadowWrite_t expQ [$];
  int           errCount = 0;
  int           flushCount = 0;
  int           writesSeen = 0;
  int           writesExpected = 0;
  int           cycle = 0;
  int           startCycle = 0;

  cacheShadowTop uut (
    .clk         (clk),
    .rst         (rst),
    .fillValid   (fillValid),
    .fill        (fill),
    .fillReady   (fillReady),
    .start       (start),
    .shadowValid (shadowValid),
    .shadowWr    (shadowWr),
    .shadowReady (shadowReady),
    .done        (done)
  );

  bind cacheShadowTop cacheShadow_sva protocolChk (
    .clk         (clk),
    .rst         (rst),
    .fillReady   (fillReady),
    .start       (start),
    .shadowValid (shadowValid),
    .shadowWr    (shadowWr),
    .shadowReady (shadowReady),
    .done        (done)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // shadow memory back-pressure
  always @(posedge clk) begin
    shadowReady <= ($urandom_range(99) >= BackPressurePct);
  end

  //////////////////////////////
  // reference model and scoreboard
  //////////////////////////////

  // line with random tag and offset at the given index
  function automatic fillReq_t makeFill(int idx, int way, logic valid, logic dirty);
    fillReq_t req;
    physAdr_t tagPart;
    tagPart = physAdr_t'($urandom()) & ~physAdr_t'(NumLines * LineBytes - 1);
    req.adr = tagPart | physAdr_t'(idx * LineBytes) | physAdr_t'($urandom_range(LineBytes - 1));
    req.way = wayIdx_t'(way);
    req.valid = valid;
    req.dirty = dirty;
    for (int k = 0; k < WordsPerLine; k++) begin
      req.data[k] = $urandom();
    end
    return req;
  endfunction

  // index comes from the bits above the line offset
  task automatic applyFill(fillReq_t req);
    int idx;
    idx = (int'(req.adr) / LineBytes) % NumLines;
    refValid[req.way][idx] = req.valid;
    refDirty[req.way][idx] = req.dirty;
    refAdr[req.way][idx] = req.adr & ~physAdr_t'(LineBytes - 1);
    refData[req.way][idx] = req.data;
  endtask

  // index outer, way inner, word ascending
  task automatic predictWrites();
    shadowWrite_t wr;
    assert (expQ.size() == 0) else begin
      errCount++;
      $display("ERR %0t: flush started with %0d writes still expected", $time, expQ.size());
    end
    expQ.delete();
    for (int i = 0; i < NumLines; i++) begin
      for (int w = 0; w < NumWays; w++) begin
        if (refValid[w][i] && refDirty[w][i]) begin
          for (int k = 0; k < WordsPerLine; k++) begin
            wr.adr = refAdr[w][i] + physAdr_t'(k * WordBytes);
            wr.data = refData[w][i][k];
            expQ.push_back(wr);
          end
        end
      end
    end
    writesSeen = 0;
    writesExpected = expQ.size();
    startCycle = cycle;
  endtask

  task automatic checkWrite();
    shadowWrite_t exp;
    assert (expQ.size() > 0) else begin
      errCount++;
      $display("ERR %0t: unexpected write adr %h data %h", $time, shadowWr.adr, shadowWr.data);
    end
    if (expQ.size() > 0) begin
      exp = expQ.pop_front();
      assert (shadowWr == exp) else begin
        errCount++;
        $display("ERR %0t: write %0d got adr %h data %h, expected adr %h data %h", $time,
                 writesSeen, shadowWr.adr, shadowWr.data, exp.adr, exp.data);
      end
    end
    writesSeen++;
  endtask

  task automatic checkDone();
    assert (writesSeen == writesExpected && expQ.size() == 0) else begin
      errCount++;
      $display("ERR %0t: flush gave %0d writes, expected %0d", $time, writesSeen, writesExpected);
    end
    // a clean cache still scans every line
    if (writesExpected == 0) begin
      assert (cycle - startCycle >= NumWays * NumLines) else begin
        errCount++;
        $display("ERR %0t: done after %0d cycles, before the scan ended", $time,
                 cycle - startCycle);
      end
    end
    flushCount++;
  endtask

  // samples pre-edge values, as the DUT sees them
  always @(posedge clk) begin
    cycle++;
    if (rst) begin
      for (int w = 0; w < NumWays; w++) begin
        for (int i = 0; i < NumLines; i++) begin
          refValid[w][i] = 1'b0;
        end
      end
      expQ.delete();
    end else begin
      if (shadowValid && shadowReady) begin
        checkWrite();
      end
      if (done) begin
        checkDone();
      end
      // snapshot sees the array before this edge's fill
      if (start && fillReady) begin
        predictWrites();
      end
      if (fillValid && fillReady) begin
        applyFill(fill);
      end
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic fillLine(fillReq_t req);
    @(posedge clk);
    fillValid <= 1'b1;
    fill <= req;
    do @(posedge clk); while (!fillReady);
    fillValid <= 1'b0;
  endtask

  task automatic runFlush();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    do @(posedge clk); while (!done);
  endtask

  // fills offered and a second start, both while the drain is busy
  task automatic flushUnderTraffic();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    fillValid <= 1'b1;
    fill <= makeFill($urandom_range(NumLines - 1), $urandom_range(NumWays - 1), 1'b1, 1'b1);
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    repeat (2) @(posedge clk);
    fillValid <= 1'b0;
    do @(posedge clk); while (!done);
  endtask

  initial begin
    int kind;
    int totalErr;
    void'($urandom(Seed));
    rst <= 1'b1;
    fillValid <= 1'b0;
    fill <= '0;
    start <= 1'b0;
    shadowReady <= 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);
    // empty cache
    runFlush();
    // every line valid and dirty
    for (int i = 0; i < NumLines; i++) begin
      for (int w = 0; w < NumWays; w++) begin
        fillLine(makeFill(i, w, 1'b1, 1'b1));
      end
    end
    runFlush();
    // some lines rewritten clean or invalid
    for (int i = 0; i < NumLines; i++) begin
      for (int w = 0; w < NumWays; w++) begin
        kind = $urandom_range(2);
        if (kind == 1) begin
          fillLine(makeFill(i, w, 1'b1, 1'b0));
        end else if (kind == 2) begin
          fillLine(makeFill(i, w, 1'b0, 1'($urandom_range(1))));
        end
      end
    end
    runFlush();
    flushUnderTraffic();
    runFlush();
    repeat (4) @(posedge clk);
    totalErr = errCount + uut.protocolChk.failCount;
    $display("flushes %0d of %0d, scoreboard errors %0d, assertion failures %0d",
             flushCount, NumFlushes, errCount, uut.protocolChk.failCount);
    if (totalErr == 0 && flushCount == NumFlushes) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("timeout: the flushes did not complete in %0d cycles", TimeoutCycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* cacheShadowTop.f */
cacheGeomPkg.sv
flushPkg.sv
cacheArray.sv
lineSnapshot.sv
shadowDrain.sv
cacheShadowTop.sv
cacheShadow_sva.sv
tb_cacheShadow.sv
